// ==== all.f ====
common/mipsPkg.sv
common/redirectIf.sv
common/execIf.sv
source/instrFetch.sv
source/controlDecode.sv
source/regFile.sv
source/aluUnit.sv
source/memWriteback.sv
source/mipsCore.sv
verification/memWriteback_chk.sv
verification/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module mipsCoreTb -f all.f -o simv > build.log 2>&1; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if [ "$simStatus" -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi
exit 0

// ==== verification/mipsCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb;
  import mipsPkg::*;

  // one program step: instruction and expected outputs
  typedef struct packed {
    logic [31:0] instrWord;
    logic [31:0] pc;
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        memWenN;  // low only for sw
    logic [6:0]  maddr;
    logic [31:0] mdata;
  } rowT;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [31:0] memReadData;
  logic        memCenN;
  logic        memWenN;
  logic [6:0]  memAddr;
  logic [31:0] memWriteData;
  logic        rfWriteEn;
  logic [4:0]  rfWriteAddr;
  logic [31:0] rfWriteData;

  logic [31:0] imem [0:255];
  logic [31:0] dataMem [0:127];
  rowT         rows [$];
  logic [31:0] pcCursor;  // pc of the next row added
  bit          tableBuilt;

  mipsCore dut (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memReadData  (memReadData),
    .memCenN      (memCenN),
    .memWenN      (memWenN),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .rfWriteEn    (rfWriteEn),
    .rfWriteAddr  (rfWriteAddr),
    .rfWriteData  (rfWriteData)
  );

  bind memWriteback memWritebackChk chk (
    .clk        (mipsCoreTb.clk),
    .rst        (rst),
    .memCenN    (memCenN),
    .memWenN    (memWenN),
    .regWriteEn (regWriteEn),
    .link       (exec.ctrl.link),
    .writeAddr  (exec.writeAddr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // data memory model
  // ==============================
  assign memReadData = memCenN ? 32'd0 : dataMem[memAddr];  // async read, only when enabled

  always @(posedge clk) begin
    if (!memCenN && !memWenN) begin
      dataMem[memAddr] = memWriteData;
    end
  end

  // galois lfsr, x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rEnc(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iEnc(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jEnc(input logic [5:0] op, input logic [25:0] field);
    return {op, field};
  endfunction

  task automatic addRow(input logic [31:0] w, input logic wen, input logic [4:0] wa,
                        input logic [31:0] wd, input logic wenN, input logic [6:0] ma,
                        input logic [31:0] md);
    rows.push_back({w, pcCursor, wen, wa, wd, wenN, ma, md});
    pcCursor = pcCursor + 32'd4;  // sequential by default
  endtask

  task automatic addWrite(input logic [31:0] w, input logic [4:0] wa, input logic [31:0] wd);
    addRow(w, 1'b1, wa, wd, 1'b1, 7'd0, 32'd0);
  endtask

  task automatic addQuiet(input logic [31:0] w);
    addRow(w, 1'b0, 5'd0, 32'd0, 1'b1, 7'd0, 32'd0);
  endtask

  task automatic addStore(input logic [31:0] w, input logic [6:0] ma, input logic [31:0] md);
    addRow(w, 1'b0, 5'd0, 32'd0, 1'b0, ma, md);
  endtask

  task automatic stopRun();
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
      stopRun();
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin : mainSeq
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] storeAddr;
    logic [31:0] word;
    logic [15:0] state;
    rowT         cur;

    rst = 1'b1;
    instr = 32'd0;
    state = 16'd27870;
    for (int a = 0; a < 128; a++) begin
      word = 32'd0;
      for (int b = 0; b < 32; b++) begin
        state = lfsrStep(state);
        word = {word[30:0], state[0]};  // one step per bit
      end
      dataMem[a] = word;
    end

    v1 = 32'd25;
    v2 = 32'hFFFF_FFF9;  // -7
    v3 = 32'h0000_0F0F;
    storeAddr = v1 + 32'd15;
    pcCursor = 32'd0;
    addWrite(iEnc(opAddi, 5'd0, 5'd1, 16'd25), 5'd1, v1);
    addWrite(iEnc(opAddi, 5'd0, 5'd2, 16'hFFF9), 5'd2, v2);
    addWrite(iEnc(opAddi, 5'd0, 5'd3, 16'h0F0F), 5'd3, v3);
    addWrite(rEnc(fnAdd, 5'd4, 5'd1, 5'd2), 5'd4, v1 + v2);
    addWrite(rEnc(fnSub, 5'd5, 5'd1, 5'd2), 5'd5, v1 - v2);
    addWrite(rEnc(fnAnd, 5'd6, 5'd3, 5'd2), 5'd6, v3 & v2);
    addWrite(rEnc(fnOr, 5'd7, 5'd3, 5'd1), 5'd7, v3 | v1);
    addWrite(rEnc(fnSlt, 5'd8, 5'd2, 5'd1), 5'd8, 32'd1);  // -7 < 25
    addWrite(rEnc(fnSlt, 5'd9, 5'd1, 5'd2), 5'd9, 32'd0);  // 25 < -7 false
    addWrite(rEnc(fnAdd, 5'd0, 5'd1, 5'd1), 5'd0, v1 + v1);  // r0 write, dropped
    addWrite(rEnc(fnOr, 5'd10, 5'd0, 5'd0), 5'd10, 32'd0);
    addStore(iEnc(opSw, 5'd1, 5'd5, 16'd15), storeAddr[8:2], v1 - v2);
    addWrite(iEnc(opLw, 5'd1, 5'd11, 16'd15), 5'd11, v1 - v2);
    addWrite(iEnc(opLw, 5'd0, 5'd12, 16'h01FC), 5'd12, dataMem[127]);  // lfsr word
    addQuiet(iEnc(opBeq, 5'd4, 5'd4, 16'd2));
    pcCursor = pcCursor + (32'd2 << 2);  // taken, two words skipped
    addQuiet(iEnc(opBeq, 5'd1, 5'd2, 16'd5));  // not taken
    addQuiet(jEnc(opJ, 26'h20));
    pcCursor = {pcCursor[31:28], 26'h20, 2'b00};
    addWrite(jEnc(opJal, 26'h40), 5'd31, pcCursor + 32'd4);
    pcCursor = {pcCursor[31:28], 26'h40, 2'b00};
    addQuiet({6'h3F, 26'h0123456});  // unknown opcode
    addWrite(iEnc(opAddi, 5'd31, 5'd13, 16'd4), 5'd13, rows[17].pc + 32'd8);  // jal link + 4
    addWrite(rEnc(fnSub, 5'd14, 5'd11, 5'd5), 5'd14, 32'd0);

    for (int a = 0; a < 256; a++) begin
      imem[a] = {6'h3F, 18'd0, 8'(a)};  // filler, never executed
    end
    foreach (rows[i]) begin
      imem[rows[i].pc[9:2]] = rows[i].instrWord;
    end
    tableBuilt = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    instr = imem[instrAddr[9:2]];
    #15;
    checkValue("instrAddr", instrAddr, 32'd0);  // still in reset
    checkValue("memCenN", 32'(memCenN), 32'd1);
    checkValue("memWenN", 32'(memWenN), 32'd1);
    checkValue("rfWriteEn", 32'(rfWriteEn), 32'd0);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      instr = imem[instrAddr[9:2]];
      #15;
      checkValue("instrAddr", instrAddr, cur.pc);
      checkValue("rfWriteEn", 32'(rfWriteEn), 32'(cur.wen));
      if (cur.wen) begin
        checkValue("rfWriteAddr", 32'(rfWriteAddr), 32'(cur.waddr));
        checkValue("rfWriteData", rfWriteData, cur.wdata);
      end
      checkValue("memWenN", 32'(memWenN), 32'(cur.memWenN));
      if (!cur.memWenN) begin
        checkValue("memCenN", 32'(memCenN), 32'd0);
        checkValue("memAddr", 32'(memAddr), 32'(cur.maddr));
        checkValue("memWriteData", memWriteData, cur.mdata);
      end
      @(negedge clk);
    end

    $display("Verification passed");
    $finish;
  end

  // watchdog, limit from table length
  initial begin : watchdog
    int limitNs;
    wait (tableBuilt);
    limitNs = (rows.size() + 10) * 40;
    #(limitNs);
    $display("run timed out after %0d ns before the program finished", limitNs);
    stopRun();
  end

endmodule

`default_nettype wire

// ==== verification/memWriteback_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module memWritebackChk (
  input logic                             clk,
  input logic                             rst,
  input logic                             memCenN,
  input logic                             memWenN,
  input logic                             regWriteEn,
  input logic                             link,
  input logic [mipsPkg::regAddrWidth-1:0] writeAddr
);
  import mipsPkg::*;

  // write strobe only inside an enabled access
  wenNeedsCen: assert property (@(posedge clk) !memWenN |-> !memCenN)
    else $error("memWenN low while memCenN high");

  // quiet outputs while in reset
  resetQuiet: assert property (@(posedge clk) rst |-> (memCenN && !regWriteEn))
    else $error("memory or register write active during reset");

  linkToR31: assert property (@(posedge clk) link |-> (writeAddr == linkReg))  // jal
    else $error("link write not aimed at register 31");

endmodule

`default_nettype wire

// ==== source/mipsCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsCore (
  input  logic                             clk,
  input  logic                             rst,
  output logic [mipsPkg::dataWidth-1:0]    instrAddr,
  input  logic [mipsPkg::dataWidth-1:0]    instr,
  input  logic [mipsPkg::dataWidth-1:0]    memReadData,
  output logic                             memCenN,
  output logic                             memWenN,
  output logic [mipsPkg::memAddrWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0]    memWriteData,
  output logic                             rfWriteEn,
  output logic [mipsPkg::regAddrWidth-1:0] rfWriteAddr,
  output logic [mipsPkg::dataWidth-1:0]    rfWriteData
);
  import mipsPkg::*;

  aluOpT                   aluOp;
  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    opB;

  redirectIf redirect ();
  execIf     exec ();

  // ==============================
  // input side
  // ==============================
  instrFetch uFetch (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .pc       (instrAddr),
    .pcPlus4  (exec.pcPlus4)
  );

  controlDecode uDecode (
    .instr     (instr),
    .ctrl      (exec.ctrl),
    .aluOp     (aluOp),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .immExt    (immExt),
    .redirect  (redirect),
    .writeAddr (exec.writeAddr)
  );

  // ==============================
  // processing
  // ==============================
  regFile uRegs (
    .clk       (clk),
    .writeEn   (rfWriteEn),
    .writeAddr (exec.writeAddr),
    .writeData (rfWriteData),
    .readAddrA (rsAddr),
    .readAddrB (rtAddr),
    .readDataA (rsData),
    .readDataB (exec.storeData)  // rt, also store data
  );

  assign opB = exec.ctrl.aluSrcImm ? immExt : exec.storeData;  // operand b mux

  aluUnit uAlu (
    .opA    (rsData),
    .opB    (opB),
    .aluOp  (aluOp),
    .result (exec.aluResult),
    .zero   (redirect.zero)
  );

  // output side, drives the memory and the register write port
  memWriteback uWb (
    .rst          (rst),
    .exec         (exec),
    .memReadData  (memReadData),
    .memCenN      (memCenN),
    .memWenN      (memWenN),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .regWriteEn   (rfWriteEn),
    .regWriteData (rfWriteData)
  );

  assign rfWriteAddr = exec.writeAddr;

endmodule

`default_nettype wire

// ==== source/memWriteback.sv ====
`timescale 1ns/10ps
`default_nettype none

module memWriteback (
  input  logic                             rst,
  execIf.writeback                         exec,
  input  logic [mipsPkg::dataWidth-1:0]    memReadData,
  output logic                             memCenN,
  output logic                             memWenN,
  output logic [mipsPkg::memAddrWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0]    memWriteData,
  output logic                             regWriteEn,
  output logic [mipsPkg::dataWidth-1:0]    regWriteData
);
  import mipsPkg::*;

  // ==============================
  // data memory side
  // ==============================
  // strobes held inactive during reset
  assign memCenN = rst | ~(exec.ctrl.memRead | exec.ctrl.memWrite);
  assign memWenN = rst | ~exec.ctrl.memWrite;

  assign memAddr      = exec.aluResult[memAddrWidth+1:2];  // byte to word address
  assign memWriteData = exec.storeData;                    // rt value for sw

  // ==============================
  // register writeback
  // ==============================
  always_comb begin
    if (exec.ctrl.link) begin
      regWriteData = exec.pcPlus4;  // jal return address
    end else if (exec.ctrl.memToReg) begin
      regWriteData = memReadData;
    end else begin
      regWriteData = exec.aluResult;
    end
  end

  assign regWriteEn = exec.ctrl.regWrite & ~rst;

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
  input  logic [mipsPkg::dataWidth-1:0] opA,
  input  logic [mipsPkg::dataWidth-1:0] opB,
  input  mipsPkg::aluOpT                aluOp,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);
  import mipsPkg::*;

  logic lessThan;

  assign lessThan = $signed(opA) < $signed(opB);  // slt is signed

  // ==============================
  // operation select
  // ==============================
  always_comb begin
    case (aluOp)
      aluAdd:  result = opA + opB;
      aluSub:  result = opA - opB;  // beq compare
      aluAnd:  result = opA & opB;
      aluOr:   result = opA | opB;
      aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
      aluNone: result = '0;
      default: result = '0;
    endcase
  end

  // flag for every op, only beq cares
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic                             clk,
  input  logic                             writeEn,
  input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]    writeData,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
  output logic [mipsPkg::dataWidth-1:0]    readDataA,
  output logic [mipsPkg::dataWidth-1:0]    readDataB
);
  import mipsPkg::*;

  // r0 has no storage
  logic [dataWidth-1:0] regs [1:31];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk) begin
    if (writeEn && (writeAddr != '0)) begin  // r0 writes dropped
      regs[writeAddr] <= writeData;
    end
  end

  // async reads, r0 hardwired zero
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== source/controlDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlDecode (
  input  logic [mipsPkg::dataWidth-1:0]    instr,
  output mipsPkg::ctrlT                    ctrl,
  output mipsPkg::aluOpT                   aluOp,
  output logic [mipsPkg::regAddrWidth-1:0] rsAddr,
  output logic [mipsPkg::regAddrWidth-1:0] rtAddr,
  output logic [mipsPkg::dataWidth-1:0]    immExt,
  redirectIf.decode                        redirect,
  output logic [mipsPkg::regAddrWidth-1:0] writeAddr
);
  import mipsPkg::*;

  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [regAddrWidth-1:0] rdAddr;

  // field split
  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign rdAddr = instr[15:11];
  assign immExt = {{16{instr[15]}}, instr[15:0]};  // sign extend

  // redirect info straight to fetch
  assign redirect.jump         = ctrl.jump;
  assign redirect.jumpField    = instr[jumpWidth-1:0];
  assign redirect.branch       = ctrl.branch;
  assign redirect.branchOffset = {immExt[dataWidth-3:0], 2'b00};  // word offset

  // ==============================
  // control and alu op per opcode
  // ==============================
  always_comb begin
    ctrl  = '0;       // unknown codes stay all clear
    aluOp = aluNone;
    case (opcode)
      opR: begin
        case (funct)
          fnAdd: aluOp = aluAdd;
          fnSub: aluOp = aluSub;
          fnAnd: aluOp = aluAnd;
          fnOr:  aluOp = aluOr;
          fnSlt: aluOp = aluSlt;
          default: aluOp = aluNone;  // bad funct
        endcase
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = (aluOp != aluNone);
      end
      opAddi: begin
        {ctrl.aluSrcImm, ctrl.regWrite} = 2'b11;
        aluOp = aluAdd;
      end
      opLw: begin
        {ctrl.aluSrcImm, ctrl.memToReg, ctrl.regWrite, ctrl.memRead} = 4'b1111;
        aluOp = aluAdd;  // base + offset
      end
      opSw: begin
        {ctrl.aluSrcImm, ctrl.memWrite} = 2'b11;
        aluOp = aluAdd;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        aluOp = aluSub;  // zero flag on equal
      end
      opJ:   ctrl.jump = 1'b1;
      opJal: {ctrl.jump, ctrl.link, ctrl.regWrite} = 3'b111;
      default: ctrl = '0;
    endcase
  end

  // write register pick, link beats regDst
  assign writeAddr = ctrl.link ? linkReg : (ctrl.regDst ? rdAddr : rtAddr);

endmodule

`default_nettype wire

// ==== source/instrFetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrFetch (
  input  logic                          clk,
  input  logic                          rst,
  redirectIf.fetch                      redirect,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus4
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcNext;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] branchTarget;
  logic                 takeBranch;

  assign pcPlus4 = pc + 32'd4;  // no delay slot, so this is also the link value

  // pseudo-direct: keep region bits of pc+4
  assign jumpTarget   = {pcPlus4[dataWidth-1:dataWidth-4], redirect.jumpField, 2'b00};
  assign branchTarget = pcPlus4 + redirect.branchOffset;  // relative to pc+4
  assign takeBranch   = redirect.branch & redirect.zero;  // beq equal

  // ==============================
  // next pc, jump wins over branch
  // ==============================
  always_comb begin
    if (redirect.jump) begin
      pcNext = jumpTarget;
    end else if (takeBranch) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;  // includes unknown ops
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;  // boot address
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// ==== common/execIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// ==============================
// execute results toward writeback
// ==============================
interface execIf;
  import mipsPkg::*;

  logic [dataWidth-1:0]    aluResult;  // also memory byte address
  logic [dataWidth-1:0]    storeData;  // rt value
  ctrlT                    ctrl;
  logic [regAddrWidth-1:0] writeAddr;  // rt, rd or linkReg
  logic [dataWidth-1:0]    pcPlus4;    // link value

  // sources are wired at the core level, one per field
  modport writeback (
    input aluResult,
    input storeData,
    input ctrl,
    input writeAddr,
    input pcPlus4
  );

endinterface

`default_nettype wire

// ==== common/redirectIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// next-pc redirect info, plain levels within the cycle
interface redirectIf;
  import mipsPkg::*;

  logic                 jump;
  logic [jumpWidth-1:0] jumpField;     // raw target field
  logic                 branch;
  logic [dataWidth-1:0] branchOffset;  // already << 2
  logic                 zero;          // from alu

  // decode side drives everything except zero
  modport decode (output jump, jumpField, branch, branchOffset);

  // fetch only listens
  modport fetch (input jump, jumpField, branch, branchOffset, zero);

endinterface

`default_nettype wire

// ==== common/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

  // ==============================
  // widths
  // ==============================
  localparam int dataWidth    = 32;  // words, regs, addresses
  localparam int regAddrWidth = 5;
  localparam int memAddrWidth = 7;   // data memory word address
  localparam int jumpWidth    = 26;  // j/jal target field

  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;  // jal destination

  // ==============================
  // opcodes and functs
  // ==============================
  localparam logic [5:0] opR    = 6'h00;
  localparam logic [5:0] opJ    = 6'h02;
  localparam logic [5:0] opJal  = 6'h03;
  localparam logic [5:0] opBeq  = 6'h04;
  localparam logic [5:0] opAddi = 6'h08;
  localparam logic [5:0] opLw   = 6'h23;
  localparam logic [5:0] opSw   = 6'h2b;

  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // alu operation, aluNone forces a zero result
  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluNone
  } aluOpT;

  // per-instruction control bits
  typedef struct packed {
    logic regDst;     // rd instead of rt
    logic aluSrcImm;  // operand b from immediate
    logic memToReg;   // load data to reg
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic branch;     // beq
    logic jump;       // j and jal
    logic link;       // jal only
  } ctrlT;

endpackage

`default_nettype wire
